/* src/rate_servo_pkg.sv */
package rate_servo_pkg;

    //////////////////////////////////////////////////
    // Bus and datapath widths
    //////////////////////////////////////////////////
    typedef logic [21:0] adr_t;       // Wishbone address
    typedef logic [31:0] dat_t;       // Wishbone data
    typedef logic [31:0] count_t;     // Triggers seen by one beam in one period
    typedef logic [17:0] thresh_t;    // Beam threshold
    typedef logic [17:0] kp_t;        // Threshold step per loop
    typedef logic [7:0]  beam_idx_t;  // Beam number for up to 256 beams

    // Threshold after reset and first value sent to the trigger
    localparam thresh_t START_THRESH = 18'd3500;

    //////////////////////////////////////////////////
    // Trigger register map
    //////////////////////////////////////////////////
    localparam adr_t TRIG_CMD_ADR    = 22'h000;  // Command on write, status on read
    localparam adr_t TRIG_COUNT_BASE = 22'h100;  // Count on read, threshold on write
    localparam adr_t TRIG_CE_BASE    = 22'h200;  // Threshold enables

    // Commands written to TRIG_CMD_ADR
    localparam dat_t CMD_START_COUNT = 32'd1;    // Begin a count period
    localparam dat_t CMD_UPDATE      = 32'd2;    // Apply all enabled thresholds

    // Status bit that goes high once the count period is over
    localparam int STATUS_DONE_BIT = 0;

endpackage

/* src/servo_regs.sv */
`timescale 1ns/1ps

module servo_regs #(
    parameter int NBEAMS       = 2,
    parameter int START_TARGET = 100,
    parameter int START_KP     = 1
) (
    input  logic                                        wb_clk_i,
    input  logic                                        arst_n_i,
    input  logic                                        wb_cyc_i,
    input  logic                                        wb_stb_i,
    input  logic                                        wb_we_i,
    input  rate_servo_pkg::adr_t                        wb_adr_i,
    input  rate_servo_pkg::dat_t                        wb_dat_i,
    output logic                                        wb_ack_o,
    output rate_servo_pkg::dat_t                        wb_dat_o,
    input  rate_servo_pkg::count_t  [NBEAMS-1:0]        counts_i,
    input  rate_servo_pkg::thresh_t [NBEAMS-1:0]        thresholds_i,
    output rate_servo_pkg::count_t                      target_o,
    output rate_servo_pkg::kp_t                         kp_o
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_ACK} state_t;

    state_t                    state;
    rate_servo_pkg::beam_idx_t sel;     // Beam picked by address bits 7:0
    logic                      sel_ok;  // Beam exists
    rate_servo_pkg::dat_t      rd_dat;  // Read mux result

    assign sel      = wb_adr_i[7:0];
    assign sel_ok   = int'(sel) < NBEAMS;
    assign wb_ack_o = (state == S_ACK);  // Exactly one cycle per access

    //////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////
    always_comb begin
        rd_dat = '0;                                      // Missing beams read zero
        if (wb_adr_i[8]) begin
            if (sel_ok) rd_dat = counts_i[sel];           // Last measured count
        end else if (wb_adr_i[9]) begin
            if (sel_ok) rd_dat = rate_servo_pkg::dat_t'(thresholds_i[sel]);
        end else if (!wb_adr_i[0]) begin
            rd_dat = rate_servo_pkg::dat_t'(kp_o);        // Gain
        end else begin
            rd_dat = target_o;                            // Target
        end
    end

    // Slave FSM plus the two writable loop settings
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= S_IDLE;
            target_o <= rate_servo_pkg::count_t'(START_TARGET);
            kp_o     <= rate_servo_pkg::kp_t'(START_KP);
        end else begin
            case (state)
                S_IDLE:  if (wb_cyc_i && wb_stb_i) state <= wb_we_i ? S_WRITE : S_READ;
                S_READ:  state <= S_ACK;
                S_WRITE: begin
                    state <= S_ACK;
                    // Writes outside the settings page are dropped
                    if (!wb_adr_i[8] && !wb_adr_i[9]) begin
                        if (wb_adr_i[0]) target_o <= wb_dat_i;
                        else             kp_o     <= rate_servo_pkg::kp_t'(wb_dat_i);
                    end
                end
                default: state <= S_IDLE;                 // Back after ack
            endcase
        end
    end

    // Response register loaded once and held through ack
    always_ff @(posedge wb_clk_i) begin
        if (state == S_READ) wb_dat_o <= rd_dat;
    end

endmodule

/* src/trig_bus_master.sv */
`timescale 1ns/1ps

module trig_bus_master (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    // Request side from the sequencer
    input  logic                 req_i,
    input  logic                 req_we_i,
    input  rate_servo_pkg::adr_t req_adr_i,
    input  rate_servo_pkg::dat_t req_wdat_i,
    output logic                 done_o,
    output rate_servo_pkg::dat_t rdata_o,
    // Wishbone master toward the trigger
    output logic                 trig_cyc_o,
    output logic                 trig_stb_o,
    output logic                 trig_we_o,
    output rate_servo_pkg::adr_t trig_adr_o,
    output rate_servo_pkg::dat_t trig_dat_o,
    input  logic                 trig_ack_i,
    input  rate_servo_pkg::dat_t trig_dat_i
);

    typedef enum logic {M_IDLE, M_WAIT} mstate_t;

    mstate_t mstate;
    logic    accept;   // Request taken this cycle
    logic    finish;   // Target answered this cycle

    assign accept = (mstate == M_IDLE) && req_i;
    assign finish = (mstate == M_WAIT) && trig_ack_i;

    // cyc and stb stay together for the whole access
    assign trig_cyc_o = (mstate == M_WAIT);
    assign trig_stb_o = (mstate == M_WAIT);

    //////////////////////////////////////////////////
    // Access control
    //////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstate <= M_IDLE;
            done_o <= 1'b0;
        end else begin
            done_o <= finish;                 // One pulse as the bus drops
            if (accept)      mstate <= M_WAIT;
            else if (finish) mstate <= M_IDLE;   // Held until ack for any delay
        end
    end

    // Bus payload stays steady while the access is open
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            trig_we_o  <= req_we_i;
            trig_adr_o <= req_adr_i;
            trig_dat_o <= req_wdat_i;
        end
        if (finish) rdata_o <= trig_dat_i;   // Valid alongside done
    end

endmodule

/* src/threshold_servo.sv */
`timescale 1ns/1ps

module threshold_servo #(
    parameter int NBEAMS       = 2,
    parameter int COUNT_MARGIN = 10,
    parameter int BOOT_CYCLES  = 31
) (
    input  logic                                 wb_clk_i,
    input  logic                                 arst_n_i,
    input  rate_servo_pkg::count_t               target_i,
    input  rate_servo_pkg::kp_t                  kp_i,
    output rate_servo_pkg::count_t  [NBEAMS-1:0] counts_o,
    output rate_servo_pkg::thresh_t [NBEAMS-1:0] thresholds_o,
    output logic                                 req_o,
    output logic                                 req_we_o,
    output rate_servo_pkg::adr_t                 req_adr_o,
    output rate_servo_pkg::dat_t                 req_wdat_o,
    input  logic                                 done_i,
    input  rate_servo_pkg::dat_t                 rdata_i
);

    localparam int BW = $clog2(BOOT_CYCLES + 1);

    typedef enum logic [2:0] {
        S_BOOT, S_START, S_POLL, S_READ, S_CALC, S_WRITE, S_ENABLE, S_UPDATE
    } state_t;

    state_t                                state;
    logic [BW-1:0]                         boot_cnt;
    rate_servo_pkg::beam_idx_t             beam;       // Beam being worked on
    logic                                  last_beam;
    logic                                  pending;    // Access open at the master
    rate_servo_pkg::thresh_t [NBEAMS-1:0]  thresh_new; // Next set applied on update
    rate_servo_pkg::count_t                count_sel;
    rate_servo_pkg::thresh_t               old_th;
    rate_servo_pkg::thresh_t               calc_th;
    logic                                  above, below;
    logic [18:0]                           up_sum;     // Extra bit catches overflow

    assign last_beam = (beam == rate_servo_pkg::beam_idx_t'(NBEAMS - 1));

    //////////////////////////////////////////////////
    // Threshold step for the selected beam
    //////////////////////////////////////////////////
    always_comb begin
        count_sel = counts_o[beam];
        old_th    = thresholds_o[beam];
        // 33 bit compares keep a target near 0 or near max from wrapping
        above  = {1'b0, count_sel} > ({1'b0, target_i} + 33'(COUNT_MARGIN));
        below  = ({1'b0, count_sel} + 33'(COUNT_MARGIN)) < {1'b0, target_i};
        up_sum = {1'b0, old_th} + {1'b0, kp_i};
        if (above)      calc_th = up_sum[18] ? '1 : up_sum[17:0];    // Raise on too many
        else if (below) calc_th = (old_th < kp_i) ? '0 : old_th - kp_i;  // Lower on too few
        else            calc_th = old_th;                          // Inside the dead band
    end

    // Opens one access and marks it pending
    task automatic issue(input logic we, input rate_servo_pkg::adr_t adr,
                         input rate_servo_pkg::dat_t dat);
        req_o      <= 1'b1;
        req_we_o   <= we;
        req_adr_o  <= adr;
        req_wdat_o <= dat;
        pending    <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Loop sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= S_BOOT;
            boot_cnt     <= BW'(BOOT_CYCLES);
            beam         <= '0;
            pending      <= 1'b0;
            req_o        <= 1'b0;
            req_we_o     <= 1'b0;
            req_adr_o    <= '0;
            req_wdat_o   <= '0;
            counts_o     <= '0;
            thresholds_o <= {NBEAMS{rate_servo_pkg::START_THRESH}};
            thresh_new   <= {NBEAMS{rate_servo_pkg::START_THRESH}};
        end else begin
            req_o <= 1'b0;                                   // Request is a pulse
            if (done_i) pending <= 1'b0;
            case (state)
                S_BOOT: begin
                    if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                    else                state    <= S_WRITE;  // Start thresholds go out first
                end
                S_START: begin
                    if (!pending) issue(1'b1, rate_servo_pkg::TRIG_CMD_ADR,
                                        rate_servo_pkg::CMD_START_COUNT);
                    else if (done_i) state <= S_POLL;
                end
                S_POLL: begin
                    if (!pending) issue(1'b0, rate_servo_pkg::TRIG_CMD_ADR, '0);
                    else if (done_i && rdata_i[rate_servo_pkg::STATUS_DONE_BIT]) begin
                        state <= S_READ;                     // Period over
                        beam  <= '0;
                    end                                      // Else ask again
                end
                S_READ: begin
                    if (!pending) begin
                        issue(1'b0, rate_servo_pkg::TRIG_COUNT_BASE + rate_servo_pkg::adr_t'(beam),
                              '0);
                    end else if (done_i) begin
                        counts_o[beam] <= rdata_i;
                        beam           <= last_beam ? '0 : beam + 1'b1;
                        if (last_beam) state <= S_CALC;
                    end
                end
                S_CALC: begin                                // One beam per cycle without the bus
                    thresh_new[beam] <= calc_th;
                    beam             <= last_beam ? '0 : beam + 1'b1;
                    if (last_beam) state <= S_WRITE;
                end
                S_WRITE: begin
                    if (!pending) begin
                        issue(1'b1, rate_servo_pkg::TRIG_COUNT_BASE + rate_servo_pkg::adr_t'(beam),
                              rate_servo_pkg::dat_t'(thresh_new[beam]));
                    end else if (done_i) begin
                        beam <= last_beam ? '0 : beam + 1'b1;
                        if (last_beam) state <= S_ENABLE;
                    end
                end
                S_ENABLE: begin
                    if (!pending) begin
                        issue(1'b1, rate_servo_pkg::TRIG_CE_BASE + rate_servo_pkg::adr_t'(beam),
                              32'd1);
                    end else if (done_i) begin
                        beam <= last_beam ? '0 : beam + 1'b1;
                        if (last_beam) state <= S_UPDATE;
                    end
                end
                default: begin                               // Global update ends the loop
                    if (!pending) issue(1'b1, rate_servo_pkg::TRIG_CMD_ADR,
                                        rate_servo_pkg::CMD_UPDATE);
                    else if (done_i) begin
                        thresholds_o <= thresh_new;          // Trigger now runs these
                        state        <= S_START;
                    end
                end
            endcase
        end
    end

endmodule

/* src/rate_servo_top.sv */
`timescale 1ns/1ps

module rate_servo_top #(
    parameter int NBEAMS       = 2,
    parameter int COUNT_MARGIN = 10,
    parameter int START_TARGET = 100,
    parameter int START_KP     = 1,
    parameter int BOOT_CYCLES  = 31
) (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    // Host slave port
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  rate_servo_pkg::adr_t wb_adr_i,
    input  rate_servo_pkg::dat_t wb_dat_i,
    output logic                 wb_ack_o,
    output rate_servo_pkg::dat_t wb_dat_o,
    // Trigger master port
    output logic                 trig_cyc_o,
    output logic                 trig_stb_o,
    output logic                 trig_we_o,
    output rate_servo_pkg::adr_t trig_adr_o,
    output rate_servo_pkg::dat_t trig_dat_o,
    input  logic                 trig_ack_i,
    input  rate_servo_pkg::dat_t trig_dat_i
);

    rate_servo_pkg::count_t               target;
    rate_servo_pkg::kp_t                  kp;
    rate_servo_pkg::count_t  [NBEAMS-1:0] counts;
    rate_servo_pkg::thresh_t [NBEAMS-1:0] thresholds;
    logic                                 req, req_we, done;
    rate_servo_pkg::adr_t                 req_adr;
    rate_servo_pkg::dat_t                 req_wdat, rdata;

    // Readback and loop settings
    servo_regs #(.NBEAMS(NBEAMS), .START_TARGET(START_TARGET), .START_KP(START_KP)) u_regs (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .counts_i(counts), .thresholds_i(thresholds), .target_o(target), .kp_o(kp)
    );

    // Loop sequencer
    threshold_servo #(.NBEAMS(NBEAMS), .COUNT_MARGIN(COUNT_MARGIN),
                      .BOOT_CYCLES(BOOT_CYCLES)) u_servo (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i), .target_i(target), .kp_i(kp),
        .counts_o(counts), .thresholds_o(thresholds),
        .req_o(req), .req_we_o(req_we), .req_adr_o(req_adr), .req_wdat_o(req_wdat),
        .done_i(done), .rdata_i(rdata)
    );

    // One trigger access at a time
    trig_bus_master u_master (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i),
        .req_i(req), .req_we_i(req_we), .req_adr_i(req_adr), .req_wdat_i(req_wdat),
        .done_o(done), .rdata_o(rdata),
        .trig_cyc_o(trig_cyc_o), .trig_stb_o(trig_stb_o), .trig_we_o(trig_we_o),
        .trig_adr_o(trig_adr_o), .trig_dat_o(trig_dat_o),
        .trig_ack_i(trig_ack_i), .trig_dat_i(trig_dat_i)
    );

endmodule

/* test/trig_target_model.sv */
`timescale 1ns/1ps

module trig_target_model #(
    parameter int NBEAMS = 2
) (
    input  logic                                 clk_i,
    input  logic                                 cyc_i,
    input  logic                                 stb_i,
    input  logic                                 we_i,
    input  rate_servo_pkg::adr_t                 adr_i,
    input  rate_servo_pkg::dat_t                 dat_i,
    output logic                                 ack_o,
    output rate_servo_pkg::dat_t                 dat_o,
    input  rate_servo_pkg::count_t  [NBEAMS-1:0] counts_i,   // Counts served this loop
    input  int                                   allow_i,    // Loops allowed to end polling
    output rate_servo_pkg::thresh_t [NBEAMS-1:0] thr_o,      // Last thresholds written
    output int                                   updates_o,  // Update commands seen
    output int                                   errors_o    // Protocol and order breaches
);

    localparam int PH_START = 0;
    localparam int PH_POLL  = 1;
    localparam int PH_COUNT = 2;
    localparam int PH_THR   = 3;
    localparam int PH_EN    = 4;
    localparam int PH_UPD   = 5;

    int                   phase;      // Step of the loop expected next
    int                   beam;       // Beam expected next within a step
    int                   polls_left;
    int                   delay;      // Cycles left before ack
    int                   allow_q;
    logic                 busy;       // Access open and not yet acked
    logic                 we_q;
    rate_servo_pkg::adr_t adr_q;
    rate_servo_pkg::dat_t dat_q;

    initial begin
        ack_o = 1'b0;
        dat_o = '0;
        thr_o = '0;
        updates_o = 0;
        errors_o = 0;
        phase = PH_THR;               // First loop opens with the start thresholds
        beam = 0;
        polls_left = 0;
        busy = 1'b0;
    end

    always @(posedge clk_i) allow_q <= allow_i;   // Stable copy of the testbench's release

    task automatic breach(input string msg);
        $display("trigger model at %0t: %s", $time, msg);
        errors_o++;
    endtask

    // Checks the loop order and moves to the next beam or step
    task automatic step(input int ph, input int b, input int next_ph, input string what);
        if (phase != ph || b != beam) begin
            breach($sformatf("%s for beam %0d came out of order", what, b));
        end
        beam = b + 1;
        if (beam >= NBEAMS) begin
            beam = 0;
            phase = next_ph;
        end
    endtask

    //////////////////////////////////////////////////
    // Register decode of one acked access
    //////////////////////////////////////////////////
    task automatic serve();
        int b;
        b = int'(adr_q[7:0]);
        dat_o = '0;
        if (adr_q == rate_servo_pkg::TRIG_CMD_ADR) begin
            if (we_q && dat_q == rate_servo_pkg::CMD_START_COUNT) begin
                if (phase != PH_START) breach("start count came out of order");
                phase = PH_POLL;
                polls_left = $urandom_range(4, 1);             // Period lasts 1 to 4 polls
            end else if (we_q && dat_q == rate_servo_pkg::CMD_UPDATE) begin
                if (phase != PH_UPD) breach("update came out of order");
                phase = PH_START;
                updates_o++;
            end else if (we_q) begin
                breach("unknown command written");
            end else begin
                if (phase != PH_POLL) breach("status poll came out of order");
                if (polls_left > 1) polls_left--;
                else if (allow_q > updates_o) begin
                    dat_o = rate_servo_pkg::dat_t'(1) << rate_servo_pkg::STATUS_DONE_BIT;
                    phase = PH_COUNT;
                    beam = 0;
                end
            end
        end else if (adr_q[21:8] == rate_servo_pkg::TRIG_COUNT_BASE[21:8] && b < NBEAMS) begin
            if (we_q) begin
                thr_o[b] = dat_q[17:0];                        // Record the new threshold
                step(PH_THR, b, PH_EN, "threshold write");
            end else begin
                dat_o = counts_i[b];
                step(PH_COUNT, b, PH_THR, "count read");
            end
        end else if (adr_q[21:8] == rate_servo_pkg::TRIG_CE_BASE[21:8] && b < NBEAMS && we_q) begin
            step(PH_EN, b, PH_UPD, "enable write");
        end else begin
            breach("access to an unknown address");
        end
    endtask

    //////////////////////////////////////////////////
    // Bus side driven on the falling edge
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (cyc_i != stb_i) breach("cyc and stb differ");
        if (ack_o) begin
            ack_o = 1'b0;                                      // Ack lasts one cycle
            busy = 1'b0;
            if (cyc_i) breach("cyc still high after ack");
        end else if (cyc_i && stb_i) begin
            if (!busy) begin
                busy = 1'b1;
                delay = $urandom_range(3, 0);
                adr_q = adr_i;
                we_q = we_i;
                dat_q = dat_i;
            end else if (adr_i != adr_q || we_i != we_q || dat_i != dat_q) begin
                breach("address, data or direction changed before ack");
            end
            if (delay == 0) begin
                serve();
                ack_o = 1'b1;
            end else delay--;
        end else if (busy) begin
            breach("cyc and stb dropped before ack");
            busy = 1'b0;
        end
    end

endmodule

/* test/tb_rate_servo.sv */
`timescale 1ns/1ps

module tb_rate_servo;

    localparam int NB    = 2;
    localparam int NROWS = 7;

    logic                                 wb_clk_i, arst_n_i;
    logic                                 wb_cyc_i, wb_stb_i, wb_we_i;
    rate_servo_pkg::adr_t                 wb_adr_i;
    rate_servo_pkg::dat_t                 wb_dat_i, wb_dat_o;
    logic                                 wb_ack_o;
    logic                                 trig_cyc_o, trig_stb_o, trig_we_o, trig_ack_i;
    rate_servo_pkg::adr_t                 trig_adr_o;
    rate_servo_pkg::dat_t                 trig_dat_o, trig_dat_i;
    rate_servo_pkg::count_t  [NB-1:0]     row_counts;
    rate_servo_pkg::thresh_t [NB-1:0]     model_thr;
    int                                   allow, updates, model_err;
    int                                   err_cnt = 0;

    //////////////////////////////////////////////////
    // Stimulus table for a margin of 10
    //////////////////////////////////////////////////
    rate_servo_pkg::count_t  tab_cnt [NROWS][NB] = '{'{200, 50}, '{105, 95}, '{1200, 500},
        '{1005, 995}, '{0, 1000}, '{10, 2000}, '{100, 0}};
    bit                      tab_wr  [NROWS] = '{0, 0, 1, 0, 1, 0, 1};  // New gain and target
    rate_servo_pkg::kp_t     tab_kp  [NROWS] = '{0, 0, 100, 0, 5000, 0, 1};
    rate_servo_pkg::count_t  tab_tgt [NROWS] = '{0, 0, 1000, 0, 1000, 0, 100};
    rate_servo_pkg::thresh_t tab_exp [NROWS][NB] = '{'{3501, 3499}, '{3501, 3499},
        '{3601, 3399}, '{3601, 3399}, '{0, 3399}, '{0, 8399}, '{0, 8398}};

    rate_servo_top #(.NBEAMS(NB)) DUT (.*);

    trig_target_model #(.NBEAMS(NB)) u_model (
        .clk_i(wb_clk_i), .cyc_i(trig_cyc_o), .stb_i(trig_stb_o), .we_i(trig_we_o),
        .adr_i(trig_adr_o), .dat_i(trig_dat_o), .ack_o(trig_ack_i), .dat_o(trig_dat_i),
        .counts_i(row_counts), .allow_i(allow), .thr_o(model_thr),
        .updates_o(updates), .errors_o(model_err)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    task automatic check_dat(input string name, input rate_servo_pkg::dat_t got,
                             input rate_servo_pkg::dat_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input rate_servo_pkg::count_t got,
                               input rate_servo_pkg::count_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_thresh(input string name, input rate_servo_pkg::thresh_t got,
                                input rate_servo_pkg::thresh_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks failed: %0d, trigger model breaches: %0d", err_cnt, model_err);
        $display("ERRORS FOUND");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Slave port accesses
    //////////////////////////////////////////////////
    task automatic slave_access(input logic we, input rate_servo_pkg::adr_t adr,
                                input rate_servo_pkg::dat_t wdat,
                                output rate_servo_pkg::dat_t rdat);
        bit got;
        got = 0;
        rdat = '0;
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        for (int i = 0; i < 20 && !got; i++) begin
            @(negedge wb_clk_i);
            if (wb_ack_o) begin                   // Ack is steady here
                rdat = wb_dat_o;
                got = 1;
            end
        end
        wb_cyc_i = 1'b0;                          // Drop before the next edge
        wb_stb_i = 1'b0;
        if (!got) abort_run("slave port never acknowledged an access");
    endtask

    task automatic wait_updates(input int n);
        bit seen;
        seen = 0;
        for (int i = 0; i < 5000 && !seen; i++) begin
            @(posedge wb_clk_i);
            if (updates >= n) seen = 1;
        end
        if (!seen) abort_run($sformatf("timeout waiting for trigger loop %0d to end", n));
    endtask

    // Compares thresholds at the trigger and the slave and counts at the slave
    task automatic check_loop(input string tag, input rate_servo_pkg::thresh_t exp0,
                              input rate_servo_pkg::thresh_t exp1, input bit with_counts);
        rate_servo_pkg::dat_t    rd;
        rate_servo_pkg::thresh_t exp [NB];
        exp[0] = exp0;
        exp[1] = exp1;
        for (int b = 0; b < NB; b++) begin
            check_thresh($sformatf("%s trigger threshold %0d", tag, b), model_thr[b], exp[b]);
            slave_access(1'b0, 22'h200 + rate_servo_pkg::adr_t'(b), '0, rd);
            check_dat($sformatf("%s wb_dat_o threshold %0d", tag, b), rd,
                      rate_servo_pkg::dat_t'(exp[b]));
            if (with_counts) begin
                slave_access(1'b0, 22'h100 + rate_servo_pkg::adr_t'(b), '0, rd);
                check_count($sformatf("%s wb_dat_o count %0d", tag, b), rd, row_counts[b]);
            end
        end
    endtask

    initial begin
        rate_servo_pkg::dat_t rd;
        void'($urandom(32'ha38));
        arst_n_i   = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        row_counts = '0;
        allow      = 0;
        repeat (3) @(negedge wb_clk_i);
        arst_n_i = 1'b1;

        // Bus stays quiet and start values read back during the boot delay
        check_dat("trig_cyc_o", rate_servo_pkg::dat_t'(trig_cyc_o), '0);
        check_dat("wb_ack_o", rate_servo_pkg::dat_t'(wb_ack_o), '0);
        slave_access(1'b0, 22'h000, '0, rd);
        check_dat("wb_dat_o gain", rd, 32'd1);
        slave_access(1'b0, 22'h001, '0, rd);
        check_dat("wb_dat_o target", rd, 32'd100);
        for (int b = 0; b < NB; b++) begin
            slave_access(1'b0, 22'h200 + rate_servo_pkg::adr_t'(b), '0, rd);
            check_dat($sformatf("wb_dat_o reset threshold %0d", b), rd,
                      rate_servo_pkg::dat_t'(rate_servo_pkg::START_THRESH));
        end
        check_dat("trig_cyc_o", rate_servo_pkg::dat_t'(trig_cyc_o), '0);  // Still booting
        wait_updates(1);                                   // Start thresholds applied
        repeat (2) @(negedge wb_clk_i);
        check_loop("start", rate_servo_pkg::START_THRESH, rate_servo_pkg::START_THRESH, 0);

        for (int r = 0; r < NROWS; r++) begin
            for (int b = 0; b < NB; b++) row_counts[b] = tab_cnt[r][b];
            if (tab_wr[r]) begin
                slave_access(1'b1, 22'h000, rate_servo_pkg::dat_t'(tab_kp[r]), rd);
                slave_access(1'b1, 22'h001, tab_tgt[r], rd);
            end
            allow = r + 2;                                 // Let this loop's period end
            wait_updates(r + 2);
            repeat (2) @(negedge wb_clk_i);
            check_loop($sformatf("row %0d", r), tab_exp[r][0], tab_exp[r][1], 1);
        end

        $display("checks failed: %0d, trigger model breaches: %0d", err_cnt, model_err);
        if (err_cnt == 0 && model_err == 0) $display("NO ERRORS");
        else $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* rate_servo.f */
src/rate_servo_pkg.sv
src/servo_regs.sv
src/trig_bus_master.sv
src/threshold_servo.sv
src/rate_servo_top.sv
test/trig_target_model.sv
test/tb_rate_servo.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f rate_servo.f --top-module tb_rate_servo

run: compile
	./obj_dir/Vtb_rate_servo | tee sim.log
	grep -q '^NO ERRORS$$' sim.log

clean:
	rm -rf obj_dir sim.log
